//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = tb_sdram_subsystem
FILELIST = src.f
SIM_ARGS = +verilator+error+limit+100
PASS_MSG = All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP) $(SIM_ARGS)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- bridge_32_16.sv
`timescale 1ns/1ns

module bridge_32_16 (
	input  logic                       clk,
	input  logic                       i_rst_n,
	input  logic                       i_h_cs,
	input  sdram_sub_pkg::word_addr_t  i_h_addr,
	input  sdram_sub_pkg::word_t       i_h_wdata,
	input  logic                       i_h_wr_en,
	input  sdram_sub_pkg::bytesel_t    i_h_bytesel,
	output sdram_sub_pkg::word_t       o_h_rdata,
	output logic                       o_h_compl,
	output logic                       o_b_cs,
	output sdram_sub_pkg::half_addr_t  o_b_addr,
	output sdram_sub_pkg::half_t       o_b_wdata,
	output logic                       o_b_wr_en,
	output sdram_sub_pkg::half_sel_t   o_b_bytesel,
	input  sdram_sub_pkg::half_t       i_b_rdata,
	input  logic                       i_b_compl
);

	logic need_lo, need_hi;
	logic phase_hi, cur_hi, last_half;
	sdram_sub_pkg::half_t lo_q;

	assign need_lo = |i_h_bytesel[1:0];
	assign need_hi = |i_h_bytesel[3:2];

	// an empty low half is skipped; an all-zero mask still runs one masked access.
	assign cur_hi = phase_hi | (~need_lo & need_hi);
	assign last_half = cur_hi | ~need_hi;

	assign o_b_cs = i_h_cs;
	assign o_b_addr = {i_h_addr, cur_hi};
	assign o_b_wdata = cur_hi ? i_h_wdata[31:16] : i_h_wdata[15:0];
	assign o_b_wr_en = i_h_wr_en;
	assign o_b_bytesel = cur_hi ? i_h_bytesel[3:2] : i_h_bytesel[1:0];

	assign o_h_compl = i_b_compl & last_half;
	assign o_h_rdata = cur_hi ? {i_b_rdata, (need_lo ? lo_q : 16'h0)} :
		{16'h0, i_b_rdata};

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n)
			phase_hi <= 1'b0;
		else if (i_b_compl)
			phase_hi <= ~last_half;
	end

	// low half kept for the word assembled on the high completion.
	always_ff @(posedge clk) begin
		if (i_b_compl && !cur_hi)
			lo_q <= i_b_rdata;
	end

endmodule

//--- sdram_controller.sv
`timescale 1ns/1ns
`include "sdram_sub_params.svh"

module sdram_controller (
	input  logic                       clk,
	input  logic                       i_rst_n,
	input  logic                       i_b_cs,
	input  sdram_sub_pkg::half_addr_t  i_b_addr,
	input  sdram_sub_pkg::half_t       i_b_wdata,
	input  logic                       i_b_wr_en,
	input  sdram_sub_pkg::half_sel_t   i_b_bytesel,
	output sdram_sub_pkg::half_t       o_b_rdata,
	output logic                       o_b_compl,
	output logic                       o_config_done,
	output logic                       o_s_ras_n,
	output logic                       o_s_cas_n,
	output logic                       o_s_wr_en,
	output logic [1:0]                 o_s_bytesel,
	output logic [12:0]                o_s_addr,
	output logic                       o_s_cs_n,
	output logic [1:0]                 o_s_banksel,
	inout  wire  [15:0]                io_s_data
);

	localparam int CNT_W = $clog2(`INIT_WAIT_CYCLES + 1);

	// {cs_n, ras_n, cas_n, wr_en}; wr_en is high when the device write enable is asserted.
	localparam logic [3:0] CMD_DESEL = 4'b1110;
	localparam logic [3:0] CMD_NOP = 4'b0110;
	localparam logic [3:0] CMD_ACT = 4'b0010;
	localparam logic [3:0] CMD_READ = 4'b0100;
	localparam logic [3:0] CMD_WRITE = 4'b0101;
	localparam logic [3:0] CMD_PRE = 4'b0011;
	localparam logic [3:0] CMD_MRS = 4'b0001;

	sdram_sub_pkg::sdram_state_t state;
	logic [CNT_W-1:0] cnt;
	logic [3:0] cmd_q;
	logic [8:0] col_q;
	logic wr_q;
	sdram_sub_pkg::half_t wdata_q;
	sdram_sub_pkg::half_sel_t sel_q;

	assign {o_s_cs_n, o_s_ras_n, o_s_cas_n, o_s_wr_en} = cmd_q;

	assign io_s_data = (state == sdram_sub_pkg::ST_WRITE) ? wdata_q : 16'hzzzz;

	// read data is on the pins in the last cas wait cycle.
	assign o_b_rdata = io_s_data;
	assign o_b_compl = (state == sdram_sub_pkg::ST_WRITE) ||
		(state == sdram_sub_pkg::ST_CAS_WAIT && cnt == '0);

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= sdram_sub_pkg::ST_INIT_WAIT;
			cnt <= CNT_W'(`INIT_WAIT_CYCLES - 1);
			cmd_q <= CMD_DESEL;
			o_config_done <= 1'b0;
		end else begin
			cmd_q <= CMD_NOP;
			case (state)
			sdram_sub_pkg::ST_INIT_WAIT: begin
				cmd_q <= CMD_DESEL;
				cnt <= cnt - 1'b1;
				if (cnt == '0) begin
					state <= sdram_sub_pkg::ST_PRECHARGE_ALL;
					cmd_q <= CMD_PRE;
				end
			end
			sdram_sub_pkg::ST_PRECHARGE_ALL: begin
				state <= sdram_sub_pkg::ST_LOAD_MODE;
				cmd_q <= CMD_MRS;
			end
			sdram_sub_pkg::ST_LOAD_MODE: begin
				state <= sdram_sub_pkg::ST_IDLE;
				o_config_done <= 1'b1;
			end
			sdram_sub_pkg::ST_IDLE: begin
				if (i_b_cs) begin
					state <= sdram_sub_pkg::ST_ACTIVATE;
					cmd_q <= CMD_ACT;
				end
			end
			sdram_sub_pkg::ST_ACTIVATE: begin
				state <= sdram_sub_pkg::ST_TRCD_WAIT;
				cnt <= CNT_W'(`TRCD_CYCLES - 2);
			end
			sdram_sub_pkg::ST_TRCD_WAIT: begin
				cnt <= cnt - 1'b1;
				if (cnt == '0) begin
					state <= wr_q ? sdram_sub_pkg::ST_WRITE : sdram_sub_pkg::ST_READ;
					cmd_q <= wr_q ? CMD_WRITE : CMD_READ;
				end
			end
			sdram_sub_pkg::ST_READ: begin
				state <= sdram_sub_pkg::ST_CAS_WAIT;
				cnt <= CNT_W'(`CAS_LATENCY - 1);
			end
			sdram_sub_pkg::ST_CAS_WAIT: begin
				cnt <= cnt - 1'b1;
				if (cnt == '0) begin
					state <= sdram_sub_pkg::ST_PRECHARGE;
					cmd_q <= CMD_PRE;
				end
			end
			sdram_sub_pkg::ST_WRITE: begin
				state <= sdram_sub_pkg::ST_PRECHARGE;
				cmd_q <= CMD_PRE;
			end
			default: begin
				state <= sdram_sub_pkg::ST_IDLE;
			end
			endcase
		end
	end

	// address and data pins follow the command chosen above.
	always_ff @(posedge clk) begin
		case (state)
		sdram_sub_pkg::ST_INIT_WAIT: begin
			o_s_addr <= 13'h0400;
			o_s_bytesel <= 2'b00;
		end
		sdram_sub_pkg::ST_PRECHARGE_ALL: begin
			o_s_addr <= {3'b000, 1'b1, 2'b00, 3'(`CAS_LATENCY), 1'b0, 3'b000};
			o_s_banksel <= 2'b00;
		end
		sdram_sub_pkg::ST_IDLE: begin
			o_s_addr <= i_b_addr[23:11];
			o_s_banksel <= i_b_addr[10:9];
			col_q <= i_b_addr[8:0];
			wr_q <= i_b_wr_en;
			wdata_q <= i_b_wdata;
			sel_q <= i_b_bytesel;
		end
		sdram_sub_pkg::ST_TRCD_WAIT: begin
			o_s_addr <= {4'b0000, col_q};
			o_s_bytesel <= wr_q ? sel_q : 2'b11;
		end
		default: begin
		end
		endcase
	end

endmodule

//--- sdram_model.sv
`timescale 1ns/1ns
`include "sdram_sub_params.svh"

module sdram_model (
	input  logic        clk,
	input  logic        i_cs_n,
	input  logic        i_ras_n,
	input  logic        i_cas_n,
	input  logic        i_wr_en,
	input  logic [1:0]  i_bytesel,
	input  logic [12:0] i_addr,
	input  logic [1:0]  i_banksel,
	inout  wire  [15:0] io_data
);

	logic [15:0] mem [logic [23:0]];
	logic [12:0] open_row [0:3];
	logic [23:0] loc;
	logic [15:0] rd_word;
	logic [3:0] rd_cnt = 4'd0;

	// bank, open row of that bank and column.
	assign loc = {open_row[i_banksel], i_banksel, i_addr[8:0]};

	// read data sits on the pins for one cycle, CAS_LATENCY edges after the command.
	assign io_data = (rd_cnt == 4'd1) ? rd_word : 16'hzzzz;

	always @(posedge clk) begin
		logic [15:0] merged;
		if (rd_cnt != 4'd0)
			rd_cnt <= rd_cnt - 4'd1;
		if (!i_cs_n && !i_ras_n && i_cas_n && !i_wr_en)
			open_row[i_banksel] <= i_addr;
		if (!i_cs_n && i_ras_n && !i_cas_n) begin
			merged = mem.exists(loc) ? mem[loc] : 16'h0000;
			if (i_wr_en) begin
				if (i_bytesel[0])
					merged[7:0] = io_data[7:0];
				if (i_bytesel[1])
					merged[15:8] = io_data[15:8];
				mem[loc] = merged;
			end else begin
				rd_word <= merged;
				rd_cnt <= 4'(`CAS_LATENCY);
			end
		end
	end

endmodule

//--- sdram_port_arbiter.sv
`timescale 1ns/1ns
`include "sdram_sub_params.svh"

module sdram_port_arbiter (
	input  logic                       clk,
	input  logic                       i_rst_n,
	input  logic                       i_d_access,
	input  sdram_sub_pkg::word_addr_t  i_d_addr,
	input  sdram_sub_pkg::word_t       i_d_wr_val,
	input  logic                       i_d_wr_en,
	input  sdram_sub_pkg::bytesel_t    i_d_bytesel,
	output logic                       o_d_ack,
	output sdram_sub_pkg::word_t       o_d_data,
	input  logic                       i_i_access,
	input  sdram_sub_pkg::word_addr_t  i_i_addr,
	output logic                       o_i_ack,
	output sdram_sub_pkg::word_t       o_i_data,
	output logic                       o_h_cs,
	output sdram_sub_pkg::word_addr_t  o_h_addr,
	output sdram_sub_pkg::word_t       o_h_wdata,
	output logic                       o_h_wr_en,
	output sdram_sub_pkg::bytesel_t    o_h_bytesel,
	input  sdram_sub_pkg::word_t       i_h_rdata,
	input  logic                       i_h_compl,
	input  logic                       i_config_done
);

	logic d_start, i_start, d_ctrl;
	logic d_granted, i_granted;
	logic sel_d, sel_i, d_mem_ack;
	logic ctrl_ack;
	sdram_sub_pkg::word_t ctrl_data;
	sdram_sub_pkg::word_addr_t host_addr;

	assign d_start = i_d_access &&
		(i_d_addr >= `SDRAM_BASE) && (i_d_addr < `SDRAM_BASE + `SDRAM_SIZE);
	assign i_start = i_i_access &&
		(i_i_addr >= `SDRAM_BASE) && (i_i_addr < `SDRAM_BASE + `SDRAM_SIZE);
	assign d_ctrl = i_d_access && (i_d_addr == `CTRL_BASE);

	// a started access keeps the bridge until it completes.
	assign sel_d = d_granted | (~i_granted & d_start);
	assign sel_i = i_granted | (~d_granted & ~d_start & ~d_ctrl & i_start);

	assign host_addr = sel_d ? i_d_addr : i_i_addr;
	assign o_h_cs = sel_d | sel_i;
	assign o_h_addr = host_addr - `SDRAM_BASE;
	assign o_h_wdata = i_d_wr_val;
	assign o_h_wr_en = sel_d & i_d_wr_en;
	assign o_h_bytesel = sel_d ? i_d_bytesel : 4'b1111;

	assign d_mem_ack = sel_d & i_h_compl;
	assign o_d_ack = ctrl_ack | d_mem_ack;
	assign o_i_ack = sel_i & i_h_compl;
	assign o_d_data = ctrl_ack ? ctrl_data : (d_mem_ack ? i_h_rdata : '0);
	assign o_i_data = o_i_ack ? i_h_rdata : '0;

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			d_granted <= 1'b0;
			i_granted <= 1'b0;
		end else begin
			d_granted <= sel_d & ~i_h_compl;
			i_granted <= sel_i & ~i_h_compl;
		end
	end

	// status ack waits out an instruction access so the two acks never meet.
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n)
			ctrl_ack <= 1'b0;
		else
			ctrl_ack <= d_ctrl & ~ctrl_ack & ~sel_i;
	end

	always_ff @(posedge clk) begin
		if (d_ctrl && !i_d_wr_en)
			ctrl_data <= {31'b0, i_config_done};
	end

endmodule

//--- sdram_sub_params.svh
`ifndef SDRAM_SUB_PARAMS_SVH
`define SDRAM_SUB_PARAMS_SVH

// sdram window in 32-bit word addresses.
`define SDRAM_BASE 30'h0000_4000
`define SDRAM_SIZE 30'h0000_4000

// single status word on the data bus, outside the sdram window.
`define CTRL_BASE 30'h0000_1000

// power-up wait, kept short for simulation.
`define INIT_WAIT_CYCLES 64

`define CAS_LATENCY 2
`define TRCD_CYCLES 2

`endif

//--- sdram_sub_pkg.sv
package sdram_sub_pkg;

	typedef logic [29:0] word_addr_t;
	typedef logic [30:0] half_addr_t;
	typedef logic [31:0] word_t;
	typedef logic [15:0] half_t;
	typedef logic [3:0] bytesel_t;
	typedef logic [1:0] half_sel_t;

	typedef enum logic [3:0] {
		ST_INIT_WAIT,
		ST_PRECHARGE_ALL,
		ST_LOAD_MODE,
		ST_IDLE,
		ST_ACTIVATE,
		ST_TRCD_WAIT,
		ST_READ,
		ST_CAS_WAIT,
		ST_WRITE,
		ST_PRECHARGE
	} sdram_state_t;

endpackage

//--- sdram_sub_sva.sv
`timescale 1ns/1ns

module sdram_sub_sva (
	input logic clk,
	input logic i_rst_n,
	input logic i_d_access,
	input logic i_i_access,
	input logic i_d_ack,
	input logic i_i_ack,
	input logic i_h_cs,
	input logic i_h_compl
);

	int fail_count = 0;

	assert property (@(posedge clk) disable iff (!i_rst_n) !(i_d_ack && i_i_ack))
	else begin
		fail_count++;
		$error("d_ack and i_ack are high in the same cycle");
	end

	// the bridge request is held until its completion.
	assert property (@(posedge clk) disable iff (!i_rst_n) (i_h_cs && !i_h_compl) |=> i_h_cs)
	else begin
		fail_count++;
		$error("h_cs dropped before h_compl");
	end

	assert property (@(posedge clk) disable iff (!i_rst_n) i_d_ack |-> i_d_access)
	else begin
		fail_count++;
		$error("d_ack without a data access");
	end

	assert property (@(posedge clk) disable iff (!i_rst_n) i_i_ack |-> i_i_access)
	else begin
		fail_count++;
		$error("i_ack without an instruction access");
	end

endmodule

//--- sdram_subsystem.sv
`timescale 1ns/1ns

module sdram_subsystem (
	input  logic                       clk,
	input  logic                       i_rst_n,
	input  logic                       i_d_access,
	input  sdram_sub_pkg::word_addr_t  i_d_addr,
	input  sdram_sub_pkg::word_t       i_d_wr_val,
	input  logic                       i_d_wr_en,
	input  sdram_sub_pkg::bytesel_t    i_d_bytesel,
	output logic                       o_d_ack,
	output sdram_sub_pkg::word_t       o_d_data,
	input  logic                       i_i_access,
	input  sdram_sub_pkg::word_addr_t  i_i_addr,
	output logic                       o_i_ack,
	output sdram_sub_pkg::word_t       o_i_data,
	output logic                       o_s_ras_n,
	output logic                       o_s_cas_n,
	output logic                       o_s_wr_en,
	output logic [1:0]                 o_s_bytesel,
	output logic [12:0]                o_s_addr,
	output logic                       o_s_cs_n,
	output logic [1:0]                 o_s_banksel,
	inout  wire  [15:0]                io_s_data
);

	logic h_cs, h_wr_en, h_compl;
	sdram_sub_pkg::word_addr_t h_addr;
	sdram_sub_pkg::word_t h_wdata, h_rdata;
	sdram_sub_pkg::bytesel_t h_bytesel;
	logic b_cs, b_wr_en, b_compl;
	sdram_sub_pkg::half_addr_t b_addr;
	sdram_sub_pkg::half_t b_wdata, b_rdata;
	sdram_sub_pkg::half_sel_t b_bytesel;
	logic config_done;

	sdram_port_arbiter u_arbiter (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_d_access(i_d_access), .i_d_addr(i_d_addr), .i_d_wr_val(i_d_wr_val),
		.i_d_wr_en(i_d_wr_en), .i_d_bytesel(i_d_bytesel),
		.o_d_ack(o_d_ack), .o_d_data(o_d_data),
		.i_i_access(i_i_access), .i_i_addr(i_i_addr),
		.o_i_ack(o_i_ack), .o_i_data(o_i_data),
		.o_h_cs(h_cs), .o_h_addr(h_addr), .o_h_wdata(h_wdata),
		.o_h_wr_en(h_wr_en), .o_h_bytesel(h_bytesel),
		.i_h_rdata(h_rdata), .i_h_compl(h_compl), .i_config_done(config_done)
	);

	bridge_32_16 u_bridge (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_h_cs(h_cs), .i_h_addr(h_addr), .i_h_wdata(h_wdata),
		.i_h_wr_en(h_wr_en), .i_h_bytesel(h_bytesel),
		.o_h_rdata(h_rdata), .o_h_compl(h_compl),
		.o_b_cs(b_cs), .o_b_addr(b_addr), .o_b_wdata(b_wdata),
		.o_b_wr_en(b_wr_en), .o_b_bytesel(b_bytesel),
		.i_b_rdata(b_rdata), .i_b_compl(b_compl)
	);

	sdram_controller u_controller (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_b_cs(b_cs), .i_b_addr(b_addr), .i_b_wdata(b_wdata),
		.i_b_wr_en(b_wr_en), .i_b_bytesel(b_bytesel),
		.o_b_rdata(b_rdata), .o_b_compl(b_compl), .o_config_done(config_done),
		.o_s_ras_n(o_s_ras_n), .o_s_cas_n(o_s_cas_n), .o_s_wr_en(o_s_wr_en),
		.o_s_bytesel(o_s_bytesel), .o_s_addr(o_s_addr), .o_s_cs_n(o_s_cs_n),
		.o_s_banksel(o_s_banksel), .io_s_data(io_s_data)
	);

endmodule

//--- src.f
+incdir+.
sdram_sub_pkg.sv
sdram_port_arbiter.sv
bridge_32_16.sv
sdram_controller.sv
sdram_subsystem.sv
tb_clock_gen.sv
sdram_model.sv
sdram_sub_sva.sv
tb_sdram_subsystem.sv

//--- tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clk,
	output logic o_rst_n
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// reset leaves 2 ns after an edge, like the other inputs.
	initial begin
		o_rst_n = 1'b0;
		repeat (16) @(posedge clk);
		#2;
		o_rst_n = 1'b1;
	end

endmodule

//--- tb_sdram_subsystem.sv
`timescale 1ns/1ns
`include "sdram_sub_params.svh"

module tb_sdram_subsystem;

	localparam int SLICE = 40;
	localparam int ACCESS_COUNT = 80;
	localparam int TIMEOUT_CYCLES = `INIT_WAIT_CYCLES + SLICE * ACCESS_COUNT;
	localparam int SLOTS = 8;

	logic clk, rst_n;
	logic d_access, d_wr_en, d_ack, i_access, i_ack;
	sdram_sub_pkg::word_addr_t d_addr, i_addr;
	sdram_sub_pkg::word_t d_wr_val, d_data, i_data;
	sdram_sub_pkg::bytesel_t d_bytesel;
	logic s_ras_n, s_cas_n, s_wr_en, s_cs_n;
	logic [1:0] s_bytesel, s_banksel;
	logic [12:0] s_addr;
	wire [15:0] s_data;

	sdram_sub_pkg::word_t ref_mem [int];
	sdram_sub_pkg::bytesel_t masks [$] = '{4'b0001, 4'b0110, 4'b1100, 4'b0011,
		4'b1000, 4'b1010, 4'b0101, 4'b0100};
	integer seed;
	int errors = 0;
	int errors_at_start = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycle_count = 0;

	tb_clock_gen u_clock (.clk(clk), .o_rst_n(rst_n));

	sdram_subsystem UUT (
		.clk(clk), .i_rst_n(rst_n),
		.i_d_access(d_access), .i_d_addr(d_addr), .i_d_wr_val(d_wr_val),
		.i_d_wr_en(d_wr_en), .i_d_bytesel(d_bytesel), .o_d_ack(d_ack), .o_d_data(d_data),
		.i_i_access(i_access), .i_i_addr(i_addr), .o_i_ack(i_ack), .o_i_data(i_data),
		.o_s_ras_n(s_ras_n), .o_s_cas_n(s_cas_n), .o_s_wr_en(s_wr_en),
		.o_s_bytesel(s_bytesel), .o_s_addr(s_addr), .o_s_cs_n(s_cs_n),
		.o_s_banksel(s_banksel), .io_s_data(s_data)
	);

	sdram_model u_model (
		.clk(clk), .i_cs_n(s_cs_n), .i_ras_n(s_ras_n), .i_cas_n(s_cas_n),
		.i_wr_en(s_wr_en), .i_bytesel(s_bytesel), .i_addr(s_addr),
		.i_banksel(s_banksel), .io_data(s_data)
	);

	bind sdram_port_arbiter sdram_sub_sva u_sva (
		.clk(clk), .i_rst_n(i_rst_n), .i_d_access(i_d_access), .i_i_access(i_i_access),
		.i_d_ack(o_d_ack), .i_i_ack(o_i_ack), .i_h_cs(o_h_cs), .i_h_compl(i_h_compl)
	);

	// test slots spread over banks and rows.
	function automatic sdram_sub_pkg::word_addr_t slot_addr(input int idx);
		return `SDRAM_BASE + 30'(idx) * 30'h155;
	endfunction

	function automatic sdram_sub_pkg::word_t merge_bytes(input sdram_sub_pkg::word_t old,
		input sdram_sub_pkg::word_t wval, input sdram_sub_pkg::bytesel_t sel);
		sdram_sub_pkg::word_t m;
		m = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
		return (old & ~m) | (wval & m);
	endfunction

	task automatic check_word(input string name, input sdram_sub_pkg::word_t got,
		input sdram_sub_pkg::word_t exp);
		assert (got === exp)
		else begin
			$display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond)
		else begin
			$display("error at %0t ns: %s", $time, what);
			errors++;
		end
	endtask

	// holds the access until its ack, or gives up after SLICE cycles.
	task automatic bus_access(input bit on_i, input sdram_sub_pkg::word_addr_t addr,
		input logic wr, input sdram_sub_pkg::word_t val, input sdram_sub_pkg::bytesel_t sel,
		output sdram_sub_pkg::word_t rdata, output int cycles, output bit acked);
		@(posedge clk);
		#2;
		if (on_i) begin
			i_addr = addr;
			i_access = 1'b1;
		end else begin
			d_addr = addr;
			d_wr_en = wr;
			d_wr_val = val;
			d_bytesel = sel;
			d_access = 1'b1;
		end
		cycles = 0;
		acked = 1'b0;
		rdata = '0;
		while (!acked && cycles < SLICE) begin
			@(negedge clk);
			if (on_i ? i_ack : d_ack) begin
				acked = 1'b1;
				rdata = on_i ? i_data : d_data;
			end else begin
				cycles++;
			end
		end
		@(posedge clk);
		#2;
		if (on_i)
			i_access = 1'b0;
		else
			d_access = 1'b0;
	endtask

	task automatic write_slot(input int idx, input sdram_sub_pkg::word_t val,
		input sdram_sub_pkg::bytesel_t sel);
		sdram_sub_pkg::word_t rdata;
		int cycles;
		bit acked;
		ref_mem[idx] = merge_bytes(ref_mem[idx], val, sel);
		bus_access(1'b0, slot_addr(idx), 1'b1, val, sel, rdata, cycles, acked);
		check_true(acked, "write to the sdram window was not acknowledged");
	endtask

	task automatic read_slot(input bit on_i, input int idx);
		sdram_sub_pkg::word_t rdata;
		int cycles;
		bit acked;
		bus_access(on_i, slot_addr(idx), 1'b0, '0, 4'hf, rdata, cycles, acked);
		check_true(acked, "read from the sdram window was not acknowledged");
		check_word(on_i ? "o_i_data" : "o_d_data", rdata, ref_mem[idx]);
	endtask

	task automatic end_test(input int num, input string name);
		tests_run++;
		if (errors != errors_at_start)
			tests_failed++;
		$display("test %0d %s: %0d errors", num, name, errors - errors_at_start);
		errors_at_start = errors;
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: tests still running after %0d cycles", cycle_count);
			$display("Some tests failed");
			$finish;
		end
	end

	initial begin
		sdram_sub_pkg::word_t rdata, d_rdata, i_rdata;
		int cycles, d_cycles, i_cycles, polls;
		bit acked, d_acked, i_acked;
		seed = 32'hbd99_ed32;
		d_access = 1'b0;
		d_addr = '0;
		d_wr_val = '0;
		d_wr_en = 1'b0;
		d_bytesel = '0;
		i_access = 1'b0;
		i_addr = '0;
		@(posedge rst_n);

		bus_access(1'b0, `CTRL_BASE, 1'b0, '0, 4'hf, rdata, cycles, acked);
		check_true(acked && cycles == 1, "status read was not acknowledged one cycle later");
		check_word("o_d_data", rdata, 32'h0);
		polls = 0;
		while (rdata !== 32'h1 && polls < `INIT_WAIT_CYCLES / 2) begin
			bus_access(1'b0, `CTRL_BASE, 1'b0, '0, 4'hf, rdata, cycles, acked);
			polls++;
		end
		bus_access(1'b0, `CTRL_BASE, 1'b0, '0, 4'hf, rdata, cycles, acked);
		check_true(acked && cycles == 1, "status read was not acknowledged one cycle later");
		check_word("o_d_data", rdata, 32'h1);
		end_test(1, "status word");

		for (int k = 0; k < SLOTS; k++)
			write_slot(k, $random(seed), 4'hf);
		for (int k = 0; k < SLOTS; k++)
			read_slot(1'b0, k);
		end_test(2, "full word write and read");

		// some masks leave one half out entirely.
		for (int k = 0; k < SLOTS; k++)
			write_slot(k, $random(seed), masks[k]);
		for (int k = 0; k < SLOTS; k++)
			read_slot(1'b0, k);
		end_test(3, "byte masks");

		for (int k = 0; k < SLOTS; k++)
			read_slot(1'b1, k);
		end_test(4, "instruction fetch");

		fork
			bus_access(1'b0, slot_addr(2), 1'b0, '0, 4'hf, d_rdata, d_cycles, d_acked);
			bus_access(1'b1, slot_addr(5), 1'b0, '0, 4'hf, i_rdata, i_cycles, i_acked);
		join
		check_true(d_acked && i_acked, "a bus got no ack on simultaneous requests");
		check_true(d_cycles < i_cycles, "i_ack did not come after d_ack");
		check_word("o_d_data", d_rdata, ref_mem[2]);
		check_word("o_i_data", i_rdata, ref_mem[5]);
		end_test(5, "data bus priority");

		bus_access(1'b0, 30'h0000_0100, 1'b0, '0, 4'hf, rdata, cycles, acked);
		check_true(!acked, "access outside both windows was acknowledged");
		read_slot(1'b0, 3);
		end_test(6, "out of window");

		errors += UUT.u_arbiter.u_sva.fail_count;
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
